// ==== build.f ====
+incdir+bench
source/spu_fx_pkg.sv
source/spu_fx_decode.sv
source/spu_fx_addsub.sv
source/spu_fx_execute.sv
source/spu_fx_writeback.sv
source/spu_simple_fixed.sv
bench/tb_spu_simple_fixed.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_spu_simple_fixed
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_vectors.svh ====
// directed entries: name, op, format, imm, ra, rb, reg_write in, expected write, expected value
// imm10 sits in the low ten bits of imm, 3fe is -2, 3ff is -1, 200 is -512
task automatic load_vectors();
	add_vec("ah_sat_pos", spu_fx_pkg::opc_ah, 3'd0, 18'h0, {8{16'h7000}}, {8{16'h2000}}, 1, 1, {8{16'h7fff}});
	add_vec("ah_sat_neg", spu_fx_pkg::opc_ah, 3'd0, 18'h0, {8{16'h8000}}, {8{16'hffff}}, 1, 1, {8{16'h8000}});
	add_vec("ah_exact", spu_fx_pkg::opc_ah, 3'd0, 18'h0, {8{16'h0003}}, {8{16'h0004}}, 1, 1, {8{16'h0007}});
	add_vec("a_sat_pos", spu_fx_pkg::opc_a, 3'd0, 18'h0, {4{32'h7fffffff}}, {4{32'h1}}, 1, 1, {4{32'h7fffffff}});
	add_vec("a_exact", spu_fx_pkg::opc_a, 3'd0, 18'h0, {4{32'h1000}}, {4{32'hffffffff}}, 1, 1, {4{32'h0fff}});
	add_vec("sfh_exact", spu_fx_pkg::opc_sfh, 3'd0, 18'h0, {8{16'h0005}}, {8{16'h0002}}, 1, 1, {8{16'hfffd}});
	add_vec("sfh_sat_neg", spu_fx_pkg::opc_sfh, 3'd0, 18'h0, {8{16'h0001}}, {8{16'h8000}}, 1, 1, {8{16'h8000}});
	add_vec("sf_sat_pos", spu_fx_pkg::opc_sf, 3'd0, 18'h0, {4{32'h80000000}}, {4{32'h0}}, 1, 1, {4{32'h7fffffff}});
	add_vec("sf_exact", spu_fx_pkg::opc_sf, 3'd0, 18'h0, {4{32'd10}}, {4{32'd3}}, 1, 1, {4{32'hfffffff9}});
	add_vec("ahi_neg", spu_fx_pkg::opc_ahi, 3'd4, 18'h3fe, {8{16'h0005}}, '0, 1, 1, {8{16'h0003}});
	add_vec("ai_sat_neg", spu_fx_pkg::opc_ai, 3'd4, 18'h3fe, {4{32'h80000001}}, '0, 1, 1, {4{32'h80000000}});
	add_vec("sfhi_neg", spu_fx_pkg::opc_sfhi, 3'd4, 18'h3fe, {8{16'h0003}}, '0, 1, 1, {8{16'hfffb}});
	add_vec("sfi_sat_neg", spu_fx_pkg::opc_sfi, 3'd4, 18'h3fe, {4{32'h7fffffff}}, '0, 1, 1, {4{32'h80000000}});
	add_vec("andhi_neg", spu_fx_pkg::opc_andhi, 3'd4, 18'h3fe, {8{16'h1235}}, '0, 1, 1, {8{16'h1234}});
	add_vec("andi_neg", spu_fx_pkg::opc_andi, 3'd4, 18'h200, {4{32'h12345678}}, '0, 1, 1, {4{32'h12345600}});
	add_vec("orhi_neg", spu_fx_pkg::opc_orhi, 3'd4, 18'h3fe, {8{16'h1234}}, '0, 1, 1, {8{16'hfffe}});
	add_vec("ori_neg", spu_fx_pkg::opc_ori, 3'd4, 18'h3fe, {4{32'h1}}, '0, 1, 1, {4{32'hffffffff}});
	add_vec("xorhi_neg", spu_fx_pkg::opc_xorhi, 3'd4, 18'h3ff, {8{16'h1234}}, '0, 1, 1, {8{16'hedcb}});
	add_vec("xori_neg", spu_fx_pkg::opc_xori, 3'd4, 18'h3ff, {4{32'h0000ffff}}, '0, 1, 1, {4{32'hffff0000}});
	add_vec("ceqhi", spu_fx_pkg::opc_ceqhi, 3'd4, 18'h5, {4{32'h00050006}}, '0, 1, 1, {4{32'hffff0000}});
	add_vec("ceqi", spu_fx_pkg::opc_ceqi, 3'd4, 18'h5, {2{64'h00000005_00000007}}, '0, 1, 1, {2{64'hffffffff_00000000}});
	add_vec("cgthi", spu_fx_pkg::opc_cgthi, 3'd4, 18'h5, {4{32'h0006fff0}}, '0, 1, 1, {4{32'hffff0000}});
	add_vec("cgti", spu_fx_pkg::opc_cgti, 3'd4, 18'h5, {2{64'h00000004_7fffffff}}, '0, 1, 1, {2{64'h00000000_ffffffff}});
	add_vec("clgthi", spu_fx_pkg::opc_clgthi, 3'd4, 18'h5, {4{32'hfff00004}}, '0, 1, 1, {4{32'hffff0000}});
	add_vec("clgti", spu_fx_pkg::opc_clgti, 3'd4, 18'h5, {2{64'h80000000_00000005}}, '0, 1, 1, {2{64'hffffffff_00000000}});
	add_vec("ceqb", spu_fx_pkg::opc_ceqb, 3'd0, 18'h0, {8{16'h1122}}, {8{16'h1133}}, 1, 1, {8{16'hff00}});
	add_vec("cgtb", spu_fx_pkg::opc_cgtb, 3'd0, 18'h0, {8{16'h8001}}, {8{16'h7f00}}, 1, 1, {8{16'h00ff}});
	add_vec("clgtb", spu_fx_pkg::opc_clgtb, 3'd0, 18'h0, {8{16'h8000}}, {8{16'h7f01}}, 1, 1, {8{16'hff00}});
	add_vec("ceqh", spu_fx_pkg::opc_ceqh, 3'd0, 18'h0, {4{32'h12345678}}, {4{32'h12340000}}, 1, 1, {4{32'hffff0000}});
	add_vec("cgth", spu_fx_pkg::opc_cgth, 3'd0, 18'h0, {4{32'h80000001}}, {4{32'h7fff0000}}, 1, 1, {4{32'h0000ffff}});
	add_vec("clgth", spu_fx_pkg::opc_clgth, 3'd0, 18'h0, {4{32'h80000001}}, {4{32'h7fff0000}}, 1, 1, {4{32'hffffffff}});
	add_vec("ceq", spu_fx_pkg::opc_ceq, 3'd0, 18'h0, {4{32'hdeadbeef}}, {4{32'hdeadbeef}}, 1, 1, {4{32'hffffffff}});
	add_vec("cgt", spu_fx_pkg::opc_cgt, 3'd0, 18'h0, {4{32'h80000000}}, {4{32'h1}}, 1, 1, '0);
	add_vec("clgt", spu_fx_pkg::opc_clgt, 3'd0, 18'h0, {4{32'h80000000}}, {4{32'h1}}, 1, 1, {4{32'hffffffff}});
	add_vec("nop_op0", 11'h0, 3'd0, 18'h0, {4{32'h12345678}}, {4{32'h1}}, 1, 0, '0);
	add_vec("unknown_rr", 11'h7ff, 3'd0, 18'h0, {4{32'h12345678}}, {4{32'h1}}, 1, 0, '0);
	add_vec("format5", spu_fx_pkg::opc_ah, 3'd5, 18'h0, {8{16'h0003}}, {8{16'h0004}}, 1, 0, '0);
	add_vec("and_no_write", spu_fx_pkg::opc_and, 3'd0, 18'h0, {4{32'hffffffff}}, {4{32'hffffffff}}, 0, 0, '0);
endtask

// ==== bench/tb_spu_simple_fixed.sv ====
`timescale 1ns/10ps

module tb_spu_simple_fixed;
	typedef struct {
		string name;
		spu_fx_pkg::op_field_t op;
		spu_fx_pkg::format_t format;
		spu_fx_pkg::imm_t imm;
		spu_fx_pkg::quad_t ra;
		spu_fx_pkg::quad_t rb;
		spu_fx_pkg::reg_addr_t rt_addr;
		logic reg_write;
		logic exp_write;
		spu_fx_pkg::quad_t exp_value;
	} vec_t;

	logic clk = 0;
	logic reset = 1;
	spu_fx_pkg::op_field_t op = '0;
	spu_fx_pkg::format_t format = '0;
	spu_fx_pkg::reg_addr_t rt_addr = '0;
	spu_fx_pkg::quad_t ra = '0;
	spu_fx_pkg::quad_t rb = '0;
	spu_fx_pkg::imm_t imm = '0;
	logic reg_write = 0;
	spu_fx_pkg::fx_result_t wb;

	vec_t vecs[$];
	int pending[$];   // indices of entries in flight
	int tests = 0;
	int failures = 0;
	logic [31:0] lfsr = 32'h9fb9b900;

	spu_simple_fixed uut (
		.clk(clk), .reset(reset), .op(op), .format(format), .rt_addr(rt_addr),
		.ra(ra), .rb(rb), .imm(imm), .reg_write(reg_write), .wb(wb)
	);

	always #20 clk = ~clk;

	task automatic add_vec(input string name, input spu_fx_pkg::op_field_t v_op,
		input spu_fx_pkg::format_t v_fmt, input spu_fx_pkg::imm_t v_imm,
		input spu_fx_pkg::quad_t v_ra, input spu_fx_pkg::quad_t v_rb,
		input logic v_rw, input logic v_ew, input spu_fx_pkg::quad_t v_ev);
		vec_t v;
		v = '{name, v_op, v_fmt, v_imm, v_ra, v_rb, 7'(vecs.size() + 1), v_rw, v_ew, v_ev};
		vecs.push_back(v);
	endtask

	`include "tb_vectors.svh"

	// galois lfsr, one step per bit taken
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[0];
		lfsr = lfsr >> 1;
		if (fb)
			lfsr = lfsr ^ 32'h80200003;
		return fb;
	endfunction

	function automatic spu_fx_pkg::quad_t random_quad();
		spu_fx_pkg::quad_t q;
		for (int i = 0; i < spu_fx_pkg::quad_w; i++)
			q[i] = next_bit();
		return q;
	endfunction

	task automatic add_random_logic(input int count);
		spu_fx_pkg::quad_t x, y;
		for (int i = 0; i < count; i++) begin
			x = random_quad();
			y = random_quad();
			case (i % 4)
				0: add_vec($sformatf("rand_and_%0d", i), spu_fx_pkg::opc_and, 3'd0, 18'h0,
					x, y, 1, 1, x & y);
				1: add_vec($sformatf("rand_or_%0d", i), spu_fx_pkg::opc_or, 3'd0, 18'h0,
					x, y, 1, 1, x | y);
				2: add_vec($sformatf("rand_xor_%0d", i), spu_fx_pkg::opc_xor, 3'd0, 18'h0,
					x, y, 1, 1, x ^ y);
				default: add_vec($sformatf("rand_nand_%0d", i), spu_fx_pkg::opc_nand, 3'd0, 18'h0,
					x, y, 1, 1, ~(x & y));
			endcase
		end
	endtask

	task automatic compare(input string name, input logic [135:0] expected,
		input logic [135:0] actual);
		tests++;
		if (expected !== actual) begin
			failures++;
			$display("error %s expected %h actual %h", name, expected, actual);
		end else begin
			$display("ok %s", name);
		end
	endtask

	task automatic drive(input vec_t v);
		op = v.op;
		format = v.format;
		imm = v.imm;
		ra = v.ra;
		rb = v.rb;
		rt_addr = v.rt_addr;
		reg_write = v.reg_write;
	endtask

	initial begin
		int idx;
		vec_t idle;
		vec_t busy;
		load_vectors();
		add_random_logic(8);
		idle = '{"idle", '0, '0, '0, '0, '0, '0, 0, 0, '0};
		busy = '{"busy", spu_fx_pkg::opc_or, 3'd0, '0, '1, '1, 7'h7f, 1, 1, '1};
		drive(busy);   // a writing instruction sits on the inputs while reset holds
		repeat (5) @(posedge clk);
		#2;
		reset = 0;
		drive(idle);
		for (int j = 0; j < vecs.size() + 2; j++) begin
			@(posedge clk);
			#2;
			if (j < 2)
				compare("reset_idle", '0, wb);
			else begin
				idx = pending.pop_front();
				compare(vecs[idx].name, {vecs[idx].exp_value,
					vecs[idx].exp_write ? vecs[idx].rt_addr : 7'd0,
					vecs[idx].exp_write}, wb);
			end
			if (j < vecs.size()) begin
				drive(vecs[j]);
				pending.push_back(j);
			end else
				drive(idle);
		end
		$display("%0d tests, %0d failed", tests, failures);
		if (failures == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== source/spu_simple_fixed.sv ====
`timescale 1ns/10ps

module spu_simple_fixed (
	input logic clk,
	input logic reset,
	input spu_fx_pkg::op_field_t op,
	input spu_fx_pkg::format_t format,
	input spu_fx_pkg::reg_addr_t rt_addr,
	input spu_fx_pkg::quad_t ra,
	input spu_fx_pkg::quad_t rb,
	input spu_fx_pkg::imm_t imm,
	input logic reg_write,
	output spu_fx_pkg::fx_result_t wb
);
	spu_fx_pkg::fx_issue_t issue;     // stage 1 register
	spu_fx_pkg::fx_result_t result;   // combinational, ahead of stage 2

	spu_fx_decode u_decode (
		.clk(clk),
		.reset(reset),
		.op(op),
		.format(format),
		.rt_addr(rt_addr),
		.ra(ra),
		.rb(rb),
		.imm(imm),
		.reg_write(reg_write),
		.issue(issue)
	);

	spu_fx_execute u_execute (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.result(result)
	);

	spu_fx_writeback u_writeback (
		.clk(clk),
		.reset(reset),
		.result(result),
		.wb(wb)
	);

endmodule

// ==== source/spu_fx_writeback.sv ====
`timescale 1ns/10ps

module spu_fx_writeback (
	input logic clk,
	input logic reset,
	input spu_fx_pkg::fx_result_t result,
	output spu_fx_pkg::fx_result_t wb
);

	// stage 2, captures every cycle since nothing ever stalls
	always_ff @(posedge clk) begin
		if (reset) begin
			wb <= '0;
		end else begin
			wb <= result;
		end
	end

	// a non-writing slot leaves decode as a nop, so its value must arrive empty
	assert property (@(posedge clk) disable iff (reset)
		!wb.reg_write |-> wb.value == '0);

endmodule

// ==== source/spu_fx_execute.sv ====
`timescale 1ns/10ps

module spu_fx_execute (
	input logic clk,
	input logic reset,
	input spu_fx_pkg::fx_issue_t issue,
	output spu_fx_pkg::fx_result_t result
);
	spu_fx_pkg::quad_t sum;
	spu_fx_pkg::quad_t cmp_lane [3];   // compare masks, one per element size
	spu_fx_pkg::quad_t value;

	spu_fx_addsub u_addsub (
		.a(issue.a),
		.b(issue.b),
		.size(issue.size),
		.subtract(issue.op == spu_fx_pkg::fx_sub_from),
		.sum(sum)
	);

	for (genvar s = 0; s < 3; s++) begin : g_cmp
		for (genvar i = 0; i < (spu_fx_pkg::quad_bytes >> s); i++) begin : g_elem
			logic [0:(spu_fx_pkg::byte_w << s) - 1] ae, be;
			logic hit;

			assign ae = issue.a[i * $bits(ae) +: $bits(ae)];
			assign be = issue.b[i * $bits(be) +: $bits(be)];

			always_comb begin
				case (issue.op)
					spu_fx_pkg::fx_cmp_eq: hit = (ae == be);
					spu_fx_pkg::fx_cmp_gt: hit = ($signed(ae) > $signed(be));
					default: hit = (ae > be);   // logical, unsigned
				endcase
			end

			assign cmp_lane[s][i * $bits(ae) +: $bits(ae)] = {$bits(ae){hit}};
		end
	end

	always_comb begin
		case (issue.op)
			spu_fx_pkg::fx_add, spu_fx_pkg::fx_sub_from: value = sum;
			spu_fx_pkg::fx_and: value = issue.a & issue.b;
			spu_fx_pkg::fx_or: value = issue.a | issue.b;
			spu_fx_pkg::fx_xor: value = issue.a ^ issue.b;
			spu_fx_pkg::fx_nand: value = ~(issue.a & issue.b);
			spu_fx_pkg::fx_cmp_eq, spu_fx_pkg::fx_cmp_gt, spu_fx_pkg::fx_cmp_lgt: begin
				value = cmp_lane[issue.size];
			end
			default: value = '0;   // nop
		endcase
	end

	assign result = '{value: value, rt_addr: issue.rt_addr, reg_write: issue.reg_write};

	// the instruction set has no byte add, decode must never pair one up
	assert property (@(posedge clk) disable iff (reset)
		issue.op inside {spu_fx_pkg::fx_add, spu_fx_pkg::fx_sub_from}
		|-> issue.size != spu_fx_pkg::elem_byte);

endmodule

// ==== source/spu_fx_addsub.sv ====
`timescale 1ns/10ps

module spu_fx_addsub (
	input spu_fx_pkg::quad_t a,
	input spu_fx_pkg::quad_t b,
	input spu_fx_pkg::elem_size_e size,
	input logic subtract,   // b minus a instead of a plus b
	output spu_fx_pkg::quad_t sum
);
	spu_fx_pkg::quad_t lane [1:2];   // index is the elem_size_e code

	// s = 1 for halfwords, s = 2 for words
	for (genvar s = 1; s < 3; s++) begin : g_size
		for (genvar i = 0; i < (spu_fx_pkg::quad_bytes >> s); i++) begin : g_elem
			logic [0:(spu_fx_pkg::byte_w << s) - 1] ae, be;
			logic [0:(spu_fx_pkg::byte_w << s)] wide;   // guard bit in front

			assign ae = a[i * $bits(ae) +: $bits(ae)];
			assign be = b[i * $bits(be) +: $bits(be)];
			assign wide = subtract ? {be[0], be} - {ae[0], ae} : {ae[0], ae} + {be[0], be};

			// guard and sign disagree on overflow, the guard bit holds the true sign
			assign lane[s][i * $bits(ae) +: $bits(ae)] = (wide[0] == wide[1]) ?
				wide[1:$bits(ae)] : {wide[0], {($bits(ae) - 1){~wide[0]}}};
		end
	end

	assign sum = (size == spu_fx_pkg::elem_word) ? lane[2] : lane[1];

endmodule

// ==== source/spu_fx_decode.sv ====
`timescale 1ns/10ps

module spu_fx_decode (
	input logic clk,
	input logic reset,
	input spu_fx_pkg::op_field_t op,
	input spu_fx_pkg::format_t format,
	input spu_fx_pkg::reg_addr_t rt_addr,
	input spu_fx_pkg::quad_t ra,
	input spu_fx_pkg::quad_t rb,
	input spu_fx_pkg::imm_t imm,
	input logic reg_write,
	output spu_fx_pkg::fx_issue_t issue
);
	typedef struct packed {
		spu_fx_pkg::fx_op_e op;
		spu_fx_pkg::elem_size_e size;
	} dec_t;

	dec_t dec;
	logic live;
	spu_fx_pkg::quad_t b_sel;

	always_comb begin
		dec = '{spu_fx_pkg::fx_nop, spu_fx_pkg::elem_word};
		if (format == spu_fx_pkg::format_rr) begin
			case (op)
				spu_fx_pkg::opc_ah: dec = '{spu_fx_pkg::fx_add, spu_fx_pkg::elem_half};
				spu_fx_pkg::opc_a: dec = '{spu_fx_pkg::fx_add, spu_fx_pkg::elem_word};
				spu_fx_pkg::opc_sfh: dec = '{spu_fx_pkg::fx_sub_from, spu_fx_pkg::elem_half};
				spu_fx_pkg::opc_sf: dec = '{spu_fx_pkg::fx_sub_from, spu_fx_pkg::elem_word};
				spu_fx_pkg::opc_and: dec.op = spu_fx_pkg::fx_and;
				spu_fx_pkg::opc_or: dec.op = spu_fx_pkg::fx_or;
				spu_fx_pkg::opc_xor: dec.op = spu_fx_pkg::fx_xor;
				spu_fx_pkg::opc_nand: dec.op = spu_fx_pkg::fx_nand;
				spu_fx_pkg::opc_ceqb: dec = '{spu_fx_pkg::fx_cmp_eq, spu_fx_pkg::elem_byte};
				spu_fx_pkg::opc_ceqh: dec = '{spu_fx_pkg::fx_cmp_eq, spu_fx_pkg::elem_half};
				spu_fx_pkg::opc_ceq: dec = '{spu_fx_pkg::fx_cmp_eq, spu_fx_pkg::elem_word};
				spu_fx_pkg::opc_cgtb: dec = '{spu_fx_pkg::fx_cmp_gt, spu_fx_pkg::elem_byte};
				spu_fx_pkg::opc_cgth: dec = '{spu_fx_pkg::fx_cmp_gt, spu_fx_pkg::elem_half};
				spu_fx_pkg::opc_cgt: dec = '{spu_fx_pkg::fx_cmp_gt, spu_fx_pkg::elem_word};
				spu_fx_pkg::opc_clgtb: dec = '{spu_fx_pkg::fx_cmp_lgt, spu_fx_pkg::elem_byte};
				spu_fx_pkg::opc_clgth: dec = '{spu_fx_pkg::fx_cmp_lgt, spu_fx_pkg::elem_half};
				spu_fx_pkg::opc_clgt: dec = '{spu_fx_pkg::fx_cmp_lgt, spu_fx_pkg::elem_word};
				default: dec.op = spu_fx_pkg::fx_nop;   // op 0 lands here too
			endcase
		end else if (format == spu_fx_pkg::format_ri10) begin
			case (op)
				spu_fx_pkg::opc_ahi: dec = '{spu_fx_pkg::fx_add, spu_fx_pkg::elem_half};
				spu_fx_pkg::opc_ai: dec = '{spu_fx_pkg::fx_add, spu_fx_pkg::elem_word};
				spu_fx_pkg::opc_sfhi: dec = '{spu_fx_pkg::fx_sub_from, spu_fx_pkg::elem_half};
				spu_fx_pkg::opc_sfi: dec = '{spu_fx_pkg::fx_sub_from, spu_fx_pkg::elem_word};
				spu_fx_pkg::opc_andhi: dec = '{spu_fx_pkg::fx_and, spu_fx_pkg::elem_half};
				spu_fx_pkg::opc_andi: dec = '{spu_fx_pkg::fx_and, spu_fx_pkg::elem_word};
				spu_fx_pkg::opc_orhi: dec = '{spu_fx_pkg::fx_or, spu_fx_pkg::elem_half};
				spu_fx_pkg::opc_ori: dec = '{spu_fx_pkg::fx_or, spu_fx_pkg::elem_word};
				spu_fx_pkg::opc_xorhi: dec = '{spu_fx_pkg::fx_xor, spu_fx_pkg::elem_half};
				spu_fx_pkg::opc_xori: dec = '{spu_fx_pkg::fx_xor, spu_fx_pkg::elem_word};
				spu_fx_pkg::opc_ceqhi: dec = '{spu_fx_pkg::fx_cmp_eq, spu_fx_pkg::elem_half};
				spu_fx_pkg::opc_ceqi: dec = '{spu_fx_pkg::fx_cmp_eq, spu_fx_pkg::elem_word};
				spu_fx_pkg::opc_cgthi: dec = '{spu_fx_pkg::fx_cmp_gt, spu_fx_pkg::elem_half};
				spu_fx_pkg::opc_cgti: dec = '{spu_fx_pkg::fx_cmp_gt, spu_fx_pkg::elem_word};
				spu_fx_pkg::opc_clgthi: dec = '{spu_fx_pkg::fx_cmp_lgt, spu_fx_pkg::elem_half};
				spu_fx_pkg::opc_clgti: dec = '{spu_fx_pkg::fx_cmp_lgt, spu_fx_pkg::elem_word};
				default: dec.op = spu_fx_pkg::fx_nop;
			endcase
		end
	end

	// imm10 is sign-extended to the element size and copied into every element
	assign b_sel = (format != spu_fx_pkg::format_ri10) ? rb :
		(dec.size == spu_fx_pkg::elem_half) ? {8{16'(signed'(imm[8:17]))}} :
		{4{32'(signed'(imm[8:17]))}};

	// an instruction that writes nothing has no effect, so it travels as a nop
	assign live = reg_write && (dec.op != spu_fx_pkg::fx_nop);

	always_ff @(posedge clk) begin
		if (reset) begin
			issue <= '0;
		end else begin
			issue.op <= live ? dec.op : spu_fx_pkg::fx_nop;
			issue.size <= dec.size;
			issue.a <= ra;
			issue.b <= b_sel;
			issue.rt_addr <= live ? rt_addr : '0;
			issue.reg_write <= live;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		issue.op == spu_fx_pkg::fx_nop |-> !issue.reg_write);

endmodule

// ==== source/spu_fx_pkg.sv ====
package spu_fx_pkg;

	localparam int byte_w = 8;
	localparam int quad_w = 128;
	localparam int quad_bytes = quad_w / byte_w;

	// element 0 sits at bit 0, so every vector counts upward
	typedef logic [0:quad_w-1] quad_t;
	typedef logic [0:6] reg_addr_t;
	typedef logic [0:17] imm_t;     // imm10 lives in bits 8 to 17
	typedef logic [0:10] op_field_t;
	typedef logic [2:0] format_t;

	localparam format_t format_rr = 3'd0;
	localparam format_t format_ri10 = 3'd4;

	// rr opcodes, full 11 bits
	localparam op_field_t opc_ah = 11'b00011001000;
	localparam op_field_t opc_a = 11'b00011000000;
	localparam op_field_t opc_sfh = 11'b00001001000;
	localparam op_field_t opc_sf = 11'b00001000000;
	localparam op_field_t opc_and = 11'b00011000001;
	localparam op_field_t opc_or = 11'b00001000001;
	localparam op_field_t opc_xor = 11'b01001000001;
	localparam op_field_t opc_nand = 11'b00011001001;
	localparam op_field_t opc_ceqb = 11'b01111010000;
	localparam op_field_t opc_ceqh = 11'b01111001000;
	localparam op_field_t opc_ceq = 11'b01111000000;
	localparam op_field_t opc_cgtb = 11'b01001010000;
	localparam op_field_t opc_cgth = 11'b01001001000;
	localparam op_field_t opc_cgt = 11'b01001000000;
	localparam op_field_t opc_clgtb = 11'b01011010000;
	localparam op_field_t opc_clgth = 11'b01011001000;
	localparam op_field_t opc_clgt = 11'b01011000000;

	// ri10 opcodes are 8 bits wide, padded with zeros on the left
	localparam op_field_t opc_ahi = {3'b000, 8'b00011101};
	localparam op_field_t opc_ai = {3'b000, 8'b00011100};
	localparam op_field_t opc_sfhi = {3'b000, 8'b00001101};
	localparam op_field_t opc_sfi = {3'b000, 8'b00001100};
	localparam op_field_t opc_andhi = {3'b000, 8'b00010101};
	localparam op_field_t opc_andi = {3'b000, 8'b00010100};
	localparam op_field_t opc_orhi = {3'b000, 8'b00000101};
	localparam op_field_t opc_ori = {3'b000, 8'b00000100};
	localparam op_field_t opc_xorhi = {3'b000, 8'b01000101};
	localparam op_field_t opc_xori = {3'b000, 8'b01000100};
	localparam op_field_t opc_ceqhi = {3'b000, 8'b01111101};
	localparam op_field_t opc_ceqi = {3'b000, 8'b01111100};
	localparam op_field_t opc_cgthi = {3'b000, 8'b01001101};
	localparam op_field_t opc_cgti = {3'b000, 8'b01001100};
	localparam op_field_t opc_clgthi = {3'b000, 8'b01011101};
	localparam op_field_t opc_clgti = {3'b000, 8'b01011100};

	typedef enum logic [3:0] {
		fx_nop,
		fx_add,
		fx_sub_from,   // b minus a
		fx_and,
		fx_or,
		fx_xor,
		fx_nand,
		fx_cmp_eq,
		fx_cmp_gt,
		fx_cmp_lgt
	} fx_op_e;

	// encoding is log2 of the element size in bytes
	typedef enum logic [1:0] {
		elem_byte,
		elem_half,
		elem_word
	} elem_size_e;

	typedef struct packed {
		fx_op_e op;
		elem_size_e size;
		quad_t a;
		quad_t b;
		reg_addr_t rt_addr;
		logic reg_write;
	} fx_issue_t;

	typedef struct packed {
		quad_t value;
		reg_addr_t rt_addr;
		logic reg_write;
	} fx_result_t;

endpackage
